//--- flist.f
hdl/rv_pkg.sv
hdl/alu.sv
hdl/reg_file.sv
hdl/inst_decoder.sv
hdl/mem_port.sv
hdl/core_seq.sv
hdl/rv_core.sv
verif/tb_clock.sv
verif/tb_top.sv

//--- hdl/alu.sv
module alu (
    input  rv_pkg::alu_op_t         alu_op,
    input  rv_pkg::br_cond_t        br_cond,
    input  logic [rv_pkg::xlen-1:0] a,
    input  logic [rv_pkg::xlen-1:0] b,
    output logic [rv_pkg::xlen-1:0] result,
    output logic                    br_taken
);
    import rv_pkg::*;

    logic [$clog2(xlen)-1:0] shamt;
    logic                    lt_signed;
    logic                    lt_unsigned;
    logic                    equal;

    assign shamt       = b[$clog2(xlen)-1:0];
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;
    assign equal       = (a == b);

    always_comb begin
        case (alu_op)
            alu_add:    result = a + b;
            alu_sub:    result = a - b;
            alu_slt:    result = {{(xlen-1){1'b0}}, lt_signed};
            alu_sltu:   result = {{(xlen-1){1'b0}}, lt_unsigned};
            alu_xor:    result = a ^ b;
            alu_or:     result = a | b;
            alu_and:    result = a & b;
            alu_sll:    result = a << shamt;
            alu_srl:    result = a >> shamt;
            alu_sra:    result = $signed(a) >>> shamt; // Sign fill
            alu_pass_b: result = b;
            default:    result = a + b;
        endcase
    end

    always_comb begin
        case (br_cond)
            br_beq:  br_taken = equal;
            br_bne:  br_taken = !equal;
            br_blt:  br_taken = lt_signed;
            br_bge:  br_taken = !lt_signed;
            br_bltu: br_taken = lt_unsigned;
            br_bgeu: br_taken = !lt_unsigned;
            default: br_taken = 1'b0;
        endcase
    end

endmodule

//--- hdl/core_seq.sv
module core_seq #(
    parameter logic [rv_pkg::xlen-1:0] reset_pc = '0
) (
    input  logic                         memory_ready,
    input  logic                         rst_n,
    input  logic [rv_pkg::reg_idx_w-1:0] rd_idx,
    input  logic [rv_pkg::xlen-1:0]      imm,
    input  rv_pkg::inst_class_t          inst_class,
    input  logic                         use_imm,
    input  logic [rv_pkg::xlen-1:0]      rs1_data,
    input  logic [rv_pkg::xlen-1:0]      rs2_data,
    input  logic [rv_pkg::xlen-1:0]      alu_result,
    input  logic                         br_taken,
    output logic [rv_pkg::xlen-1:0]      instr,
    output logic [rv_pkg::xlen-1:0]      alu_a,
    output logic [rv_pkg::xlen-1:0]      alu_b,
    output logic                         wr_en,
    output logic [rv_pkg::reg_idx_w-1:0] wr_idx,
    output logic [rv_pkg::xlen-1:0]      wr_data,
    output logic                         access_start,
    output rv_pkg::mem_kind_t            access_kind,
    output logic [rv_pkg::xlen-1:0]      access_addr,
    output logic [rv_pkg::xlen-1:0]      access_wdata,
    input  logic                         access_done,
    input  logic [rv_pkg::xlen-1:0]      access_rdata
);
    import rv_pkg::*;

    seq_state_t      state;
    logic [xlen-1:0] pc;
    logic            waiting; // Access issued, done not yet seen
    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] pc_next;

    assign pc_plus4 = pc + xlen'(4);

    assign alu_a = (inst_class == cls_auipc) ? pc : rs1_data;
    assign alu_b = use_imm ? imm : rs2_data;

    // One request per fetch or memory phase
    assign access_start = (state == st_fetch || state == st_memory) && !waiting;
    assign access_kind  = (state == st_fetch) ? mk_fetch :
                          (inst_class == cls_store) ? mk_store : mk_load;
    assign access_addr  = (state == st_fetch) ? pc : alu_result;
    assign access_wdata = rs2_data;

    assign wr_en  = (state == st_writeback) &&
                    (inst_class inside {cls_alu_reg, cls_alu_imm, cls_lui, cls_auipc,
                                        cls_jal, cls_jalr, cls_load});
    assign wr_idx = rd_idx;

    always_comb begin
        case (inst_class)
            cls_load:          wr_data = access_rdata; // Held by the port
            cls_jal, cls_jalr: wr_data = pc_plus4;
            default:           wr_data = alu_result;
        endcase
    end

    always_comb begin
        case (inst_class)
            cls_branch: pc_next = br_taken ? pc + imm : pc_plus4;
            cls_jal:    pc_next = pc + imm;
            cls_jalr:   pc_next = {alu_result[xlen-1:1], 1'b0};
            default:    pc_next = pc_plus4;
        endcase
    end

    always_ff @(posedge memory_ready or negedge rst_n) begin
        if (!rst_n) begin
            state   <= st_fetch;
            pc      <= reset_pc;
            waiting <= 1'b0;
        end else begin
            if (access_start) begin
                waiting <= 1'b1;
            end else if (access_done) begin
                waiting <= 1'b0;
            end
            case (state)
                st_fetch: begin
                    if (access_done) begin
                        state <= st_decode;
                    end
                end
                st_decode: begin
                    if (inst_class inside {cls_load, cls_store}) begin
                        state <= st_memory;
                    end else begin
                        state <= st_writeback;
                    end
                end
                st_memory: begin
                    if (access_done) begin
                        state <= st_writeback;
                    end
                end
                default: begin
                    pc    <= pc_next;
                    state <= st_fetch;
                end
            endcase
        end
    end

    always_ff @(posedge memory_ready) begin
        if (state == st_fetch && access_done) begin
            instr <= access_rdata;
        end
    end

endmodule

//--- hdl/inst_decoder.sv
module inst_decoder (
    input  logic [rv_pkg::xlen-1:0]      instr,
    output logic [rv_pkg::reg_idx_w-1:0] rs1_idx,
    output logic [rv_pkg::reg_idx_w-1:0] rs2_idx,
    output logic [rv_pkg::reg_idx_w-1:0] rd_idx,
    output logic [rv_pkg::xlen-1:0]      imm,
    output rv_pkg::inst_class_t          inst_class,
    output rv_pkg::alu_op_t              alu_op,
    output rv_pkg::br_cond_t             br_cond,
    output logic                         use_imm
);
    import rv_pkg::*;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] imm_j;

    function automatic alu_op_t f3_to_alu(input logic [2:0] f3, input logic alt,
                                          input logic sub_ok);
        alu_op_t op;
        case (f3)
            f3_add_sub: op = (alt && sub_ok) ? alu_sub : alu_add; // No SUBI
            f3_sll:     op = alu_sll;
            f3_slt:     op = alu_slt;
            f3_sltu:    op = alu_sltu;
            f3_xor:     op = alu_xor;
            f3_srl_sra: op = alt ? alu_sra : alu_srl;
            f3_or:      op = alu_or;
            default:    op = alu_and;
        endcase
        return op;
    endfunction

    assign opcode  = instr[6:0];
    assign funct3  = instr[14:12];
    assign rs1_idx = instr[19:15];
    assign rs2_idx = instr[24:20];
    assign rd_idx  = instr[11:7];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        inst_class = cls_nop;
        alu_op     = alu_add;
        use_imm    = 1'b0;
        imm        = imm_i;
        case (opcode)
            opc_op_imm: begin
                inst_class = cls_alu_imm;
                alu_op     = f3_to_alu(funct3, instr[30], 1'b0);
                use_imm    = 1'b1;
            end
            opc_op: begin
                inst_class = cls_alu_reg;
                alu_op     = f3_to_alu(funct3, instr[30], 1'b1);
            end
            opc_lui: begin
                inst_class = cls_lui;
                alu_op     = alu_pass_b;
                use_imm    = 1'b1;
                imm        = imm_u;
            end
            opc_auipc: begin
                inst_class = cls_auipc;
                use_imm    = 1'b1;
                imm        = imm_u;
            end
            opc_branch: begin
                if (funct3[2:1] != 2'b01) begin // 010 and 011 are not branches
                    inst_class = cls_branch;
                end
                imm = imm_b;
            end
            opc_jal: begin
                inst_class = cls_jal;
                imm        = imm_j;
            end
            opc_jalr: begin
                if (funct3 == f3_jalr) begin
                    inst_class = cls_jalr;
                end
                use_imm = 1'b1;
            end
            opc_load: begin
                if (funct3 == f3_word) begin
                    inst_class = cls_load;
                end
                use_imm = 1'b1;
            end
            opc_store: begin
                if (funct3 == f3_word) begin
                    inst_class = cls_store;
                end
                use_imm = 1'b1;
                imm     = imm_s;
            end
            default: inst_class = cls_nop;
        endcase
    end

    always_comb begin
        case (funct3)
            f3_bne:  br_cond = br_bne;
            f3_blt:  br_cond = br_blt;
            f3_bge:  br_cond = br_bge;
            f3_bltu: br_cond = br_bltu;
            f3_bgeu: br_cond = br_bgeu;
            default: br_cond = br_beq; // Includes f3_beq
        endcase
    end

endmodule

//--- hdl/mem_port.sv
module mem_port (
    input  logic                    memory_ready,
    input  logic                    rst_n,
    input  logic                    access_start,
    input  rv_pkg::mem_kind_t       access_kind,
    input  logic [rv_pkg::xlen-1:0] access_addr,
    input  logic [rv_pkg::xlen-1:0] access_wdata,
    output logic                    access_done,
    output logic [rv_pkg::xlen-1:0] access_rdata,
    output logic                    mem_req,
    output logic                    mem_we,
    output logic [rv_pkg::xlen-1:0] mem_addr,
    output logic [rv_pkg::xlen-1:0] mem_wdata,
    input  logic                    mem_ack,
    input  logic [rv_pkg::xlen-1:0] mem_rdata
);
    import rv_pkg::*;

    typedef enum logic [1:0] {ms_idle, ms_req, ms_release, ms_done} port_state_t;

    port_state_t state;

    assign access_done = (state == ms_done);

    always_ff @(posedge memory_ready or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ms_idle;
            mem_req <= 1'b0;
            mem_we  <= 1'b0;
        end else begin
            case (state)
                ms_idle: begin
                    if (access_start) begin
                        mem_req <= 1'b1;
                        mem_we  <= (access_kind == mk_store);
                        state   <= ms_req;
                    end
                end
                ms_req: begin
                    if (mem_ack) begin // Data valid, drop request
                        mem_req <= 1'b0;
                        state   <= ms_release;
                    end
                end
                ms_release: begin
                    if (!mem_ack) begin // Memory has let go
                        mem_we <= 1'b0;
                        state  <= ms_done;
                    end
                end
                default: state <= ms_idle;
            endcase
        end
    end

    always_ff @(posedge memory_ready) begin
        if (state == ms_idle && access_start) begin
            mem_addr  <= access_addr;
            mem_wdata <= access_wdata;
        end
        if (state == ms_req && mem_ack) begin
            access_rdata <= mem_rdata;
        end
    end

endmodule

//--- hdl/reg_file.sv
module reg_file (
    input  logic                         memory_ready,
    input  logic                         rst_n,
    input  logic [rv_pkg::reg_idx_w-1:0] rs1_idx,
    input  logic [rv_pkg::reg_idx_w-1:0] rs2_idx,
    output logic [rv_pkg::xlen-1:0]      rs1_data,
    output logic [rv_pkg::xlen-1:0]      rs2_data,
    input  logic                         wr_en,
    input  logic [rv_pkg::reg_idx_w-1:0] wr_idx,
    input  logic [rv_pkg::xlen-1:0]      wr_data
);
    import rv_pkg::*;

    localparam int num_regs = 2 ** reg_idx_w;

    logic [xlen-1:0] regs [1:num_regs-1]; // x0 is not stored

    always_ff @(posedge memory_ready or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_idx != '0) begin
            regs[wr_idx] <= wr_data;
        end
    end

    assign rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];
    assign rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];

endmodule

//--- hdl/rv_core.sv
module rv_core #(
    parameter logic [rv_pkg::xlen-1:0] reset_pc = '0
) (
    input  logic                    memory_ready,
    input  logic                    rst_n,
    output logic                    mem_req,
    output logic                    mem_we,
    output logic [rv_pkg::xlen-1:0] mem_addr,
    output logic [rv_pkg::xlen-1:0] mem_wdata,
    input  logic                    mem_ack,
    input  logic [rv_pkg::xlen-1:0] mem_rdata
);
    import rv_pkg::*;

    logic [xlen-1:0]      instr;
    logic [reg_idx_w-1:0] rs1_idx;
    logic [reg_idx_w-1:0] rs2_idx;
    logic [reg_idx_w-1:0] rd_idx;
    logic [xlen-1:0]      imm;
    inst_class_t          inst_class;
    alu_op_t              alu_op;
    br_cond_t             br_cond;
    logic                 use_imm;
    logic [xlen-1:0]      rs1_data;
    logic [xlen-1:0]      rs2_data;
    logic [xlen-1:0]      alu_a;
    logic [xlen-1:0]      alu_b;
    logic [xlen-1:0]      alu_result;
    logic                 br_taken;
    logic                 wr_en;
    logic [reg_idx_w-1:0] wr_idx;
    logic [xlen-1:0]      wr_data;
    logic                 access_start;
    mem_kind_t            access_kind;
    logic [xlen-1:0]      access_addr;
    logic [xlen-1:0]      access_wdata;
    logic                 access_done;
    logic [xlen-1:0]      access_rdata;

    core_seq #(
        .reset_pc(reset_pc)
    ) core_seq_inst (
        .memory_ready(memory_ready),
        .rst_n(rst_n),
        .rd_idx(rd_idx),
        .imm(imm),
        .inst_class(inst_class),
        .use_imm(use_imm),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .alu_result(alu_result),
        .br_taken(br_taken),
        .instr(instr),
        .alu_a(alu_a),
        .alu_b(alu_b),
        .wr_en(wr_en),
        .wr_idx(wr_idx),
        .wr_data(wr_data),
        .access_start(access_start),
        .access_kind(access_kind),
        .access_addr(access_addr),
        .access_wdata(access_wdata),
        .access_done(access_done),
        .access_rdata(access_rdata)
    );

    inst_decoder inst_decoder_inst (
        .instr(instr),
        .rs1_idx(rs1_idx),
        .rs2_idx(rs2_idx),
        .rd_idx(rd_idx),
        .imm(imm),
        .inst_class(inst_class),
        .alu_op(alu_op),
        .br_cond(br_cond),
        .use_imm(use_imm)
    );

    reg_file reg_file_inst (
        .memory_ready(memory_ready),
        .rst_n(rst_n),
        .rs1_idx(rs1_idx),
        .rs2_idx(rs2_idx),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .wr_en(wr_en),
        .wr_idx(wr_idx),
        .wr_data(wr_data)
    );

    alu alu_inst (
        .alu_op(alu_op),
        .br_cond(br_cond),
        .a(alu_a),
        .b(alu_b),
        .result(alu_result),
        .br_taken(br_taken)
    );

    mem_port mem_port_inst (
        .memory_ready(memory_ready),
        .rst_n(rst_n),
        .access_start(access_start),
        .access_kind(access_kind),
        .access_addr(access_addr),
        .access_wdata(access_wdata),
        .access_done(access_done),
        .access_rdata(access_rdata),
        .mem_req(mem_req),
        .mem_we(mem_we),
        .mem_addr(mem_addr),
        .mem_wdata(mem_wdata),
        .mem_ack(mem_ack),
        .mem_rdata(mem_rdata)
    );

endmodule

//--- hdl/rv_pkg.sv
package rv_pkg;

    localparam int xlen      = 32;
    localparam int reg_idx_w = 5;

    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;

    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    localparam logic [2:0] f3_word = 3'b010; // LW and SW only
    localparam logic [2:0] f3_jalr = 3'b000;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_slt, alu_sltu, alu_xor, alu_or,
        alu_and, alu_sll, alu_srl, alu_sra, alu_pass_b
    } alu_op_t;

    typedef enum logic [2:0] {
        br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu
    } br_cond_t;

    typedef enum logic [3:0] {
        cls_alu_reg, cls_alu_imm, cls_lui, cls_auipc, cls_branch,
        cls_jal, cls_jalr, cls_load, cls_store, cls_nop
    } inst_class_t;

    typedef enum logic [1:0] {st_fetch, st_decode, st_memory, st_writeback} seq_state_t;

    typedef enum logic [1:0] {mk_fetch, mk_load, mk_store} mem_kind_t;

endpackage

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module tb_top -f flist.f &&
./obj_dir/Vtb_top | tee /dev/stderr | grep -q "^TEST OK$" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

//--- verif/tb_clock.sv
module tb_clock #(
    parameter int period = 4
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(period / 2) clk = ~clk; // Free running

endmodule

//--- verif/tb_top.sv
module tb_top;
    import rv_pkg::*;

    logic        memory_ready;
    logic        rst_n = 1'b0;
    logic        mem_req;
    logic        mem_we;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic        mem_ack = 1'b0;
    logic [31:0] mem_rdata = '0;

    logic [31:0] img [0:1023]; // Program image, copied into mem during reset
    logic [31:0] mem [0:1023];
    int          pc_w;
    logic [31:0] exp_addr [0:63];
    logic [31:0] exp_data [0:63];
    int          exp_cnt;
    logic [31:0] st_addr [0:63];
    logic [31:0] st_data [0:63];
    int          seen_cnt;
    int          cmp_ptr;
    int          cmp_errs;
    int          main_errs;
    int          tests_run;
    int          tests_failed;
    bit          slow_mem;
    bit          halted;
    bit          aborted;
    bit          prev_req;
    bit          req_d;
    logic [15:0] op_lfsr = 16'd54;
    logic [15:0] dly_lfsr = 16'd54;
    logic [31:0] last_fetch;
    int          delay;
    bit          busy;
    logic [31:0] alu_a_val;
    logic [31:0] alu_b_val;
    logic [11:0] alu_imms [0:7];
    logic [4:0]  alu_sh;

    tb_clock #(.period(4)) tb_clock_inst (.clk(memory_ready));

    rv_core #(.reset_pc(32'h0)) rv_core_inst (
        .memory_ready(memory_ready),
        .rst_n(rst_n),
        .mem_req(mem_req),
        .mem_we(mem_we),
        .mem_addr(mem_addr),
        .mem_wdata(mem_wdata),
        .mem_ack(mem_ack),
        .mem_rdata(mem_rdata)
    );

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(inout logic [15:0] st, input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v  = {v[30:0], st[0]};
            st = lfsr_next(st);
        end
    endtask

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp,
                         inout int errs);
        if (got !== exp) begin
            errs++;
            $display("error at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // Expected values from the ISA rules
    function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0]; // Sign fill
                end
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic bit ref_branch(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, opc_op};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opc_store};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
    endfunction

    task automatic emit(input logic [31:0] w);
        img[pc_w] = w;
        pc_w++;
    endtask

    function automatic logic [31:0] here();
        return pc_w * 4;
    endfunction

    task automatic load_imm(input logic [4:0] rd, input logic [31:0] v);
        logic [31:0] up;
        up = v + 32'h800; // ADDI sign extends the low part
        emit({up[31:12], rd, opc_lui});
        emit(enc_i(v[11:0], rd, 3'b000, rd, opc_op_imm));
    endtask

    task automatic store_word(input logic [4:0] rs, input int slot, input logic [31:0] exp);
        logic [31:0] a;
        a = 32'h400 + slot * 4;
        emit(enc_s(a[11:0], rs, 5'd0));
        exp_addr[exp_cnt] = a;
        exp_data[exp_cnt] = exp;
        exp_cnt++;
    endtask

    task automatic begin_prog();
        logic [31:0] a;
        for (int i = 0; i < 1024; i++) begin
            a      = i * 4;
            img[i] = ~a ^ {a[15:0], a[31:16]};
        end
        pc_w    = 0;
        exp_cnt = 0;
    endtask

    // Memory model, answers the four-phase handshake
    always @(posedge memory_ready) begin
        logic [31:0] v;
        if (!rst_n) begin
            for (int i = 0; i < 1024; i++) begin
                mem[i] = img[i];
            end
            mem_ack <= 1'b0;
            busy     = 1'b0;
            seen_cnt = 0;
        end else if (mem_req && !mem_ack) begin
            if (!busy) begin
                busy = 1'b1;
                take_bits(dly_lfsr, 2, v);
                delay = slow_mem ? 3 : v;
            end
            if (delay == 0) begin
                busy     = 1'b0;
                mem_ack <= 1'b1;
                if (mem_we) begin
                    mem[mem_addr[11:2]] = mem_wdata;
                    st_addr[seen_cnt]   = mem_addr;
                    st_data[seen_cnt]   = mem_wdata;
                    seen_cnt++;
                end else begin
                    mem_rdata <= mem[mem_addr[11:2]];
                end
            end else begin
                delay--;
            end
        end else if (!mem_req && mem_ack) begin
            mem_ack <= 1'b0;
        end
    end

    // Halt is a fetch of the same address twice in a row
    always @(posedge memory_ready) begin
        if (!rst_n) begin
            halted     = 1'b0;
            last_fetch = '1;
            req_d      = 1'b0;
        end else begin
            if (mem_req && !req_d && !mem_we) begin
                if (mem_addr == last_fetch) begin
                    halted = 1'b1;
                end
                last_fetch = mem_addr;
            end
            req_d = mem_req;
        end
    end

    // Compare process for stores and handshake order
    always @(posedge memory_ready) begin
        if (!rst_n) begin
            cmp_ptr  = 0;
            prev_req = 1'b0;
        end else begin
            if (mem_req && !prev_req && mem_ack) begin
                cmp_errs++;
                $display("mem_req rose at %0t while mem_ack was still high", $time);
            end
            prev_req = mem_req;
            if (cmp_ptr < seen_cnt) begin
                if (cmp_ptr >= exp_cnt) begin
                    cmp_errs++;
                    $display("unexpected store to %h at %0t", st_addr[cmp_ptr], $time);
                end else begin
                    check("store mem_addr", st_addr[cmp_ptr], exp_addr[cmp_ptr], cmp_errs);
                    check("store mem_wdata", st_data[cmp_ptr], exp_data[cmp_ptr], cmp_errs);
                end
                cmp_ptr++;
            end
        end
    end

    task automatic run_prog(input string name, input bit slow);
        int n;
        int start;
        if (aborted) return;
        start    = main_errs + cmp_errs;
        slow_mem = slow;
        @(posedge memory_ready);
        rst_n <= 1'b0;
        repeat (5) begin
            @(posedge memory_ready);
            check("mem_req in reset", {31'b0, mem_req}, 32'h0, main_errs);
        end
        rst_n <= 1'b1;
        n = 0;
        while (!mem_req && n < 100) begin
            @(posedge memory_ready);
            n++;
        end
        check("first fetch mem_addr", mem_addr, 32'h0, main_errs);
        check("first fetch mem_we", {31'b0, mem_we}, 32'h0, main_errs);
        n = 0;
        while (!halted && n < 40000) begin
            @(posedge memory_ready);
            n++;
        end
        if (!halted) begin
            main_errs++;
            aborted = 1'b1;
            $display("%s: program did not reach its halt loop in time", name);
        end
        n = 0;
        while (cmp_ptr < seen_cnt && n < 10) begin
            @(posedge memory_ready);
            n++;
        end
        if (!aborted && cmp_ptr != exp_cnt) begin
            main_errs++;
            $display("%s: saw %0d stores, expected %0d", name, cmp_ptr, exp_cnt);
        end
        tests_run++;
        if (main_errs + cmp_errs != start) begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, main_errs + cmp_errs - start);
        end else begin
            $display("%s: passed", name);
        end
    endtask

    task automatic build_alu_prog();
        int          slot;
        logic [11:0] im;
        begin_prog();
        load_imm(5'd1, alu_a_val);
        load_imm(5'd2, alu_b_val);
        slot = 0;
        for (int f = 0; f < 8; f++) begin
            for (int alt = 0; alt < 2; alt++) begin
                if (alt == 0 || f == 0 || f == 5) begin
                    emit(enc_r(alt == 1 ? 7'h20 : 7'h00, 5'd2, 5'd1, f[2:0], 5'd3));
                    store_word(5'd3, slot, ref_alu(f[2:0], alt[0], alu_a_val, alu_b_val));
                    slot++;
                end
                if (alt == 0 || f == 5) begin
                    im = (f == 1 || f == 5) ? {alt[0] ? 7'h20 : 7'h00, alu_sh} : alu_imms[f];
                    emit(enc_i(im, 5'd1, f[2:0], 5'd4, opc_op_imm));
                    store_word(5'd4, slot, ref_alu(f[2:0], alt[0] && f == 5, alu_a_val,
                                                   {{20{im[11]}}, im}));
                    slot++;
                end
            end
        end
        emit(enc_j(21'd0, 5'd0));
    endtask

    task automatic build_branch_prog();
        logic [31:0] pa [0:2];
        logic [31:0] pb [0:2];
        logic [2:0]  conds [0:5];
        logic [31:0] m;
        logic [31:0] sa;
        int          k;
        pa = '{32'd7, 32'hFFFF_FFFC, 32'd9};
        pb = '{32'd7, 32'd9, 32'hFFFF_FFFC};
        conds = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        begin_prog();
        k = 0;
        for (int c = 0; c < 6; c++) begin
            for (int p = 0; p < 3; p++) begin
                load_imm(5'd5, pa[p]);
                load_imm(5'd6, pb[p]);
                emit(enc_b(13'd16, 5'd6, 5'd5, conds[c]));
                m  = 32'h100 + k * 2;
                sa = 32'h400 + k * 4;
                emit(enc_i(m[11:0], 5'd0, 3'b000, 5'd7, opc_op_imm));
                emit(enc_s(sa[11:0], 5'd7, 5'd0)); // Not-taken marker
                emit(enc_j(21'd12, 5'd0));
                emit(enc_i(m[11:0] + 12'd1, 5'd0, 3'b000, 5'd7, opc_op_imm));
                store_word(5'd7, k, m + {31'b0, ref_branch(conds[c], pa[p], pb[p])});
                k++;
            end
        end
        emit(enc_j(21'd0, 5'd0));
    endtask

    task automatic build_jump_prog();
        logic [31:0] p0;
        logic [31:0] p1;
        logic [31:0] p2;
        logic [31:0] target;
        begin_prog();
        p0 = here();
        emit(enc_j(21'd8, 5'd1));
        emit(enc_s(12'h7FC, 5'd0, 5'd0)); // Skipped by JAL
        store_word(5'd1, 0, p0 + 32'd4);
        p1 = here();
        emit({20'h12345, 5'd2, opc_auipc});
        store_word(5'd2, 1, p1 + 32'h1234_5000);
        p2 = here();
        emit({20'h0, 5'd3, opc_auipc});
        emit(enc_i(12'd17, 5'd3, 3'b000, 5'd4, opc_jalr));
        target = (p2 + 32'd17) & ~32'd1;
        while (here() < target) begin
            emit(enc_s(12'h7F8, 5'd0, 5'd0)); // Skipped by JALR
        end
        store_word(5'd4, 2, p2 + 32'd8);
        emit(enc_i(12'h05A, 5'd0, 3'b000, 5'd5, opc_op_imm));
        store_word(5'd5, 3, 32'h5A);
        emit(enc_j(21'd0, 5'd0));
    endtask

    task automatic build_load_prog();
        logic [31:0] v;
        begin_prog();
        take_bits(op_lfsr, 32, v);
        img[32'h700 >> 2] = v;
        emit(enc_i(12'h700, 5'd0, 3'b010, 5'd1, opc_load));
        emit(enc_i(12'h123, 5'd1, 3'b000, 5'd2, opc_op_imm));
        store_word(5'd2, 0, v + 32'h123);
        emit(enc_r(7'h00, 5'd1, 5'd1, 3'b000, 5'd0));
        emit(enc_i(12'd55, 5'd0, 3'b000, 5'd0, opc_op_imm));
        store_word(5'd0, 1, 32'h0);
        emit(enc_j(21'd0, 5'd0));
    endtask

    initial begin
        logic [31:0] v;
        begin_prog();
        emit(enc_j(21'd0, 5'd0));
        run_prog("reset and first fetch", 1'b0);

        take_bits(op_lfsr, 32, alu_a_val);
        take_bits(op_lfsr, 32, alu_b_val);
        for (int i = 0; i < 8; i++) begin
            take_bits(op_lfsr, 12, v);
            alu_imms[i] = v[11:0];
        end
        take_bits(op_lfsr, 5, v);
        alu_sh = v[4:0];
        build_alu_prog();
        run_prog("alu operations", 1'b0);

        build_branch_prog();
        run_prog("branches", 1'b0);
        build_jump_prog();
        run_prog("jumps and auipc", 1'b0);
        build_load_prog();
        run_prog("load and x0", 1'b0);
        build_alu_prog();
        run_prog("alu under back-pressure", 1'b1);

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed,
                 main_errs + cmp_errs);
        if (main_errs + cmp_errs == 0 && !aborted) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
